// ==== logic/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    // Datapath and register file sizing
    localparam int unsigned XLEN        = 32;
    localparam int unsigned PRF_ENTRIES = 64;
    localparam int unsigned PRF_ID_W    = 6;
    localparam int unsigned ROB_ID_W    = 6;

    // Shift amount width for RV32
    localparam int unsigned SHAMT_W = 5;

    // Fall-through pc step and link offset
    localparam int unsigned INSN_BYTES = 4;

    typedef enum logic [4:0] {
        // Integer ALU
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_LUI,
        // Conditional branches, then JAL
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL
    } t_exe_op;

endpackage

`default_nettype wire

// ==== logic/exe_alu.sv ====
`default_nettype none

module exe_alu (
    input  exe_pkg::t_exe_op          op,
    input  logic [exe_pkg::XLEN-1:0]  a,
    input  logic [exe_pkg::XLEN-1:0]  b,

    output logic                      resvld,
    output logic [exe_pkg::XLEN-1:0]  result
);

    import exe_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        resvld = 1'b1;
        result = '0;
        case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            OP_SRA:  result = $signed(a) >>> shamt;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            // Immediate arrives already shifted into place
            OP_LUI:  result = b;
            default: begin
                resvld = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/exe_branch.sv ====
`default_nettype none

module exe_branch (
    input  exe_pkg::t_exe_op          op,
    input  logic [exe_pkg::XLEN-1:0]  a,
    input  logic [exe_pkg::XLEN-1:0]  b,
    input  logic [exe_pkg::XLEN-1:0]  pc,
    input  logic [exe_pkg::XLEN-1:0]  imm,
    input  logic                      pred_taken,

    output logic                      resvld,
    output logic                      taken,
    output logic [exe_pkg::XLEN-1:0]  target,
    output logic [exe_pkg::XLEN-1:0]  link,
    output logic                      mispred
);

    import exe_pkg::*;

    logic [XLEN-1:0] pc_next;

    assign pc_next = pc + XLEN'(INSN_BYTES);

    always_comb begin
        resvld = 1'b1;
        taken  = 1'b0;
        case (op)
            OP_BEQ:  taken = (a == b);
            OP_BNE:  taken = (a != b);
            OP_BLT:  taken = ($signed(a) < $signed(b));
            OP_BGE:  taken = ($signed(a) >= $signed(b));
            OP_BLTU: taken = (a < b);
            OP_BGEU: taken = (a >= b);
            OP_JAL:  taken = 1'b1;
            default: begin
                resvld = 1'b0;
            end
        endcase
    end

    assign target  = taken ? pc + imm : pc_next;
    assign link    = pc_next;
    assign mispred = resvld && (taken != pred_taken);

endmodule

`default_nettype wire

// ==== logic/exe_lane.sv ====
`default_nettype none

module exe_lane (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          flush,

    input  logic                          ex0_valid,
    input  exe_pkg::t_exe_op              ex0_op,
    input  logic [exe_pkg::XLEN-1:0]      ex0_src1_val,
    input  logic [exe_pkg::XLEN-1:0]      ex0_src2_val,
    input  logic                          ex0_use_imm,
    input  logic [exe_pkg::XLEN-1:0]      ex0_imm,
    input  logic [exe_pkg::XLEN-1:0]      ex0_pc,
    input  logic                          ex0_pred_taken,
    input  logic [exe_pkg::PRF_ID_W-1:0]  ex0_pdst,
    input  logic [exe_pkg::ROB_ID_W-1:0]  ex0_robid,

    output logic                          ex1_valid,
    output logic                          ex1_wr,
    output logic [exe_pkg::PRF_ID_W-1:0]  ex1_pdst,
    output logic [exe_pkg::ROB_ID_W-1:0]  ex1_robid,
    output logic [exe_pkg::XLEN-1:0]      ex1_result,
    output logic                          ex1_mispred,
    output logic [exe_pkg::XLEN-1:0]      ex1_target
);

    import exe_pkg::*;

    logic [XLEN-1:0] opb;

    logic            alu_resvld;
    logic [XLEN-1:0] alu_result;

    logic            br_resvld;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] br_link;
    logic            br_mispred;

    logic            jal_link;
    logic [XLEN-1:0] result;
    logic            wr;

    assign opb = ex0_use_imm ? ex0_imm : ex0_src2_val;

    exe_alu exe_alu_inst (
        .op     (ex0_op),
        .a      (ex0_src1_val),
        .b      (opb),
        .resvld (alu_resvld),
        .result (alu_result)
    );

    // Branch compares registers and takes the immediate as offset
    exe_branch exe_branch_inst (
        .op         (ex0_op),
        .a          (ex0_src1_val),
        .b          (ex0_src2_val),
        .pc         (ex0_pc),
        .imm        (ex0_imm),
        .pred_taken (ex0_pred_taken),
        .resvld     (br_resvld),
        .taken      (br_taken),
        .target     (br_target),
        .link       (br_link),
        .mispred    (br_mispred)
    );

    assign jal_link = br_resvld && br_taken && (ex0_op == OP_JAL);
    assign result   = jal_link ? br_link : alu_result;
    assign wr       = (alu_resvld || jal_link) && (ex0_pdst != '0);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex1_valid <= 1'b0;
        end else if (!stall) begin
            ex1_valid <= ex0_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex1_wr      <= wr;
            ex1_pdst    <= ex0_pdst;
            ex1_robid   <= ex0_robid;
            ex1_result  <= result;
            ex1_mispred <= br_mispred;
            ex1_target  <= br_target;
        end
    end

endmodule

`default_nettype wire

// ==== logic/exe_regread.sv ====
`default_nettype none

module exe_regread #(
    parameter int NUM_LANES = 2
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          stall,
    input  logic                                          flush,

    input  logic [NUM_LANES-1:0]                          iss_valid,
    input  exe_pkg::t_exe_op [NUM_LANES-1:0]              iss_op,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   iss_src1,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   iss_src2,
    input  logic [NUM_LANES-1:0]                          iss_use_imm,
    input  logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       iss_imm,
    input  logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       iss_pc,
    input  logic [NUM_LANES-1:0]                          iss_pred_taken,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   iss_pdst,
    input  logic [NUM_LANES-1:0][exe_pkg::ROB_ID_W-1:0]   iss_robid,

    input  logic [NUM_LANES-1:0]                          wb_en,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   wb_pdst,
    input  logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       wb_data,

    output logic [NUM_LANES-1:0]                          ex0_valid,
    output exe_pkg::t_exe_op [NUM_LANES-1:0]              ex0_op,
    output logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       ex0_src1_val,
    output logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       ex0_src2_val,
    output logic [NUM_LANES-1:0]                          ex0_use_imm,
    output logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       ex0_imm,
    output logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       ex0_pc,
    output logic [NUM_LANES-1:0]                          ex0_pred_taken,
    output logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   ex0_pdst,
    output logic [NUM_LANES-1:0][exe_pkg::ROB_ID_W-1:0]   ex0_robid
);

    import exe_pkg::*;

    logic [XLEN-1:0] prf [PRF_ENTRIES];

    logic [NUM_LANES-1:0][XLEN-1:0] rd1_val;
    logic [NUM_LANES-1:0][XLEN-1:0] rd2_val;

    // Write ports in lane order, so the youngest writer lands last
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PRF_ENTRIES; r++) begin
                prf[r] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_LANES; w++) begin
                if (wb_en[w] && wb_pdst[w] != '0) begin
                    prf[wb_pdst[w]] <= wb_data[w];
                end
            end
        end
    end

    // Read ports with same-cycle write-back bypass
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rd1_val[l] = prf[iss_src1[l]];
            rd2_val[l] = prf[iss_src2[l]];
            for (int w = 0; w < NUM_LANES; w++) begin
                if (wb_en[w] && wb_pdst[w] == iss_src1[l]) begin
                    rd1_val[l] = wb_data[w];
                end
                if (wb_en[w] && wb_pdst[w] == iss_src2[l]) begin
                    rd2_val[l] = wb_data[w];
                end
            end
            // x0 is hardwired
            if (iss_src1[l] == '0) begin
                rd1_val[l] = '0;
            end
            if (iss_src2[l] == '0) begin
                rd2_val[l] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex0_valid <= '0;
        end else if (!stall) begin
            ex0_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex0_op         <= iss_op;
            ex0_src1_val   <= rd1_val;
            ex0_src2_val   <= rd2_val;
            ex0_use_imm    <= iss_use_imm;
            ex0_imm        <= iss_imm;
            ex0_pc         <= iss_pc;
            ex0_pred_taken <= iss_pred_taken;
            ex0_pdst       <= iss_pdst;
            ex0_robid      <= iss_robid;
        end
    end

endmodule

`default_nettype wire

// ==== logic/exe_complete.sv ====
`default_nettype none

module exe_complete #(
    parameter int NUM_LANES = 2
) (
    input  logic                                          stall,

    input  logic [NUM_LANES-1:0]                          ex1_valid,
    input  logic [NUM_LANES-1:0]                          ex1_wr,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   ex1_pdst,
    input  logic [NUM_LANES-1:0][exe_pkg::ROB_ID_W-1:0]   ex1_robid,
    input  logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       ex1_result,
    input  logic [NUM_LANES-1:0]                          ex1_mispred,
    input  logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       ex1_target,

    output logic [NUM_LANES-1:0]                          wb_en,
    output logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   wb_pdst,
    output logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       wb_data,

    output logic [NUM_LANES-1:0]                          cmp_valid,
    output logic [NUM_LANES-1:0][exe_pkg::ROB_ID_W-1:0]   cmp_robid,
    output logic [NUM_LANES-1:0]                          cmp_mispred,

    output logic                                          redirect_valid,
    output logic [exe_pkg::XLEN-1:0]                      redirect_pc
);

    import exe_pkg::*;

    logic [NUM_LANES-1:0] live;
    logic                 redir_hit;
    logic [XLEN-1:0]      redir_tgt;

    // Held ops report once, after stall drops
    assign live = ex1_valid & {NUM_LANES{~stall}};

    assign wb_en       = live & ex1_wr;
    assign wb_pdst     = ex1_pdst;
    assign wb_data     = ex1_result;
    assign cmp_valid   = live;
    assign cmp_robid   = ex1_robid;
    assign cmp_mispred = live & ex1_mispred;

    // Scan young to old so the oldest mispredict is left standing
    always_comb begin
        redir_hit = 1'b0;
        redir_tgt = '0;
        for (int l = NUM_LANES - 1; l >= 0; l--) begin
            if (live[l] && ex1_mispred[l]) begin
                redir_hit = 1'b1;
                redir_tgt = ex1_target[l];
            end
        end
    end

    assign redirect_valid = redir_hit;
    assign redirect_pc    = redir_tgt;

endmodule

`default_nettype wire

// ==== logic/exe_cluster.sv ====
`default_nettype none

module exe_cluster #(
    parameter int NUM_LANES = 2
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          stall,
    input  logic                                          flush,

    input  logic [NUM_LANES-1:0]                          iss_valid,
    input  exe_pkg::t_exe_op [NUM_LANES-1:0]              iss_op,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   iss_src1,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   iss_src2,
    input  logic [NUM_LANES-1:0]                          iss_use_imm,
    input  logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       iss_imm,
    input  logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       iss_pc,
    input  logic [NUM_LANES-1:0]                          iss_pred_taken,
    input  logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   iss_pdst,
    input  logic [NUM_LANES-1:0][exe_pkg::ROB_ID_W-1:0]   iss_robid,

    output logic [NUM_LANES-1:0]                          wb_en,
    output logic [NUM_LANES-1:0][exe_pkg::PRF_ID_W-1:0]   wb_pdst,
    output logic [NUM_LANES-1:0][exe_pkg::XLEN-1:0]       wb_data,

    output logic [NUM_LANES-1:0]                          cmp_valid,
    output logic [NUM_LANES-1:0][exe_pkg::ROB_ID_W-1:0]   cmp_robid,
    output logic [NUM_LANES-1:0]                          cmp_mispred,

    output logic                                          redirect_valid,
    output logic [exe_pkg::XLEN-1:0]                      redirect_pc
);

    import exe_pkg::*;

    // EX0 issue registers
    logic [NUM_LANES-1:0]               ex0_valid;
    t_exe_op [NUM_LANES-1:0]            ex0_op;
    logic [NUM_LANES-1:0][XLEN-1:0]     ex0_src1_val;
    logic [NUM_LANES-1:0][XLEN-1:0]     ex0_src2_val;
    logic [NUM_LANES-1:0]               ex0_use_imm;
    logic [NUM_LANES-1:0][XLEN-1:0]     ex0_imm;
    logic [NUM_LANES-1:0][XLEN-1:0]     ex0_pc;
    logic [NUM_LANES-1:0]               ex0_pred_taken;
    logic [NUM_LANES-1:0][PRF_ID_W-1:0] ex0_pdst;
    logic [NUM_LANES-1:0][ROB_ID_W-1:0] ex0_robid;

    // EX1 lane results
    logic [NUM_LANES-1:0]               ex1_valid;
    logic [NUM_LANES-1:0]               ex1_wr;
    logic [NUM_LANES-1:0][PRF_ID_W-1:0] ex1_pdst;
    logic [NUM_LANES-1:0][ROB_ID_W-1:0] ex1_robid;
    logic [NUM_LANES-1:0][XLEN-1:0]     ex1_result;
    logic [NUM_LANES-1:0]               ex1_mispred;
    logic [NUM_LANES-1:0][XLEN-1:0]     ex1_target;

    exe_regread #(
        .NUM_LANES (NUM_LANES)
    ) exe_regread_inst (
        .clk,
        .rst,
        .stall,
        .flush,
        .iss_valid,
        .iss_op,
        .iss_src1,
        .iss_src2,
        .iss_use_imm,
        .iss_imm,
        .iss_pc,
        .iss_pred_taken,
        .iss_pdst,
        .iss_robid,
        .wb_en,
        .wb_pdst,
        .wb_data,
        .ex0_valid,
        .ex0_op,
        .ex0_src1_val,
        .ex0_src2_val,
        .ex0_use_imm,
        .ex0_imm,
        .ex0_pc,
        .ex0_pred_taken,
        .ex0_pdst,
        .ex0_robid
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        exe_lane exe_lane_inst (
            .clk            (clk),
            .rst            (rst),
            .stall          (stall),
            .flush          (flush),
            .ex0_valid      (ex0_valid[i]),
            .ex0_op         (ex0_op[i]),
            .ex0_src1_val   (ex0_src1_val[i]),
            .ex0_src2_val   (ex0_src2_val[i]),
            .ex0_use_imm    (ex0_use_imm[i]),
            .ex0_imm        (ex0_imm[i]),
            .ex0_pc         (ex0_pc[i]),
            .ex0_pred_taken (ex0_pred_taken[i]),
            .ex0_pdst       (ex0_pdst[i]),
            .ex0_robid      (ex0_robid[i]),
            .ex1_valid      (ex1_valid[i]),
            .ex1_wr         (ex1_wr[i]),
            .ex1_pdst       (ex1_pdst[i]),
            .ex1_robid      (ex1_robid[i]),
            .ex1_result     (ex1_result[i]),
            .ex1_mispred    (ex1_mispred[i]),
            .ex1_target     (ex1_target[i])
        );
    end

    exe_complete #(
        .NUM_LANES (NUM_LANES)
    ) exe_complete_inst (
        .stall,
        .ex1_valid,
        .ex1_wr,
        .ex1_pdst,
        .ex1_robid,
        .ex1_result,
        .ex1_mispred,
        .ex1_target,
        .wb_en,
        .wb_pdst,
        .wb_data,
        .cmp_valid,
        .cmp_robid,
        .cmp_mispred,
        .redirect_valid,
        .redirect_pc
    );

endmodule

`default_nettype wire

// ==== dv/tb_exe_cluster.sv ====
`default_nettype none

module tb_exe_cluster;

    timeunit 1ns;
    timeprecision 1ps;

    import exe_pkg::*;

    localparam int NUM_LANES = 2;

    // Group counts per test phase
    localparam int N_ZERO  = 32;
    localparam int N_ALU   = 150;
    localparam int N_CHAIN = 40;
    localparam int N_BR    = 60;
    localparam int N_STALL = 40;
    localparam int N_FLUSH = 20;
    localparam int N_IDLE  = 12;
    localparam int TOTAL_GROUPS = N_ZERO + N_ALU + N_CHAIN + N_BR + N_STALL + 3 * N_FLUSH + N_IDLE;
    localparam int MAX_CYCLES   = 2 * TOTAL_GROUPS + 200;

    typedef struct packed {
        logic            wr;
        logic            mispred;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] target;
    } exp_t;

    logic clk;
    logic rst;
    logic stall;
    logic flush;

    logic [NUM_LANES-1:0]                iss_valid;
    t_exe_op [NUM_LANES-1:0]             iss_op;
    logic [NUM_LANES-1:0][PRF_ID_W-1:0]  iss_src1;
    logic [NUM_LANES-1:0][PRF_ID_W-1:0]  iss_src2;
    logic [NUM_LANES-1:0]                iss_use_imm;
    logic [NUM_LANES-1:0][XLEN-1:0]      iss_imm;
    logic [NUM_LANES-1:0][XLEN-1:0]      iss_pc;
    logic [NUM_LANES-1:0]                iss_pred_taken;
    logic [NUM_LANES-1:0][PRF_ID_W-1:0]  iss_pdst;
    logic [NUM_LANES-1:0][ROB_ID_W-1:0]  iss_robid;

    logic [NUM_LANES-1:0]                wb_en;
    logic [NUM_LANES-1:0][PRF_ID_W-1:0]  wb_pdst;
    logic [NUM_LANES-1:0][XLEN-1:0]      wb_data;
    logic [NUM_LANES-1:0]                cmp_valid;
    logic [NUM_LANES-1:0][ROB_ID_W-1:0]  cmp_robid;
    logic [NUM_LANES-1:0]                cmp_mispred;
    logic                                redirect_valid;
    logic [XLEN-1:0]                     redirect_pc;

    // Model of the register file and both pipeline stages
    logic [XLEN-1:0]     rf_model [PRF_ENTRIES];
    logic                m0_valid [NUM_LANES];
    t_exe_op             m0_op [NUM_LANES];
    logic [XLEN-1:0]     m0_a [NUM_LANES];
    logic [XLEN-1:0]     m0_s2 [NUM_LANES];
    logic [XLEN-1:0]     m0_imm [NUM_LANES];
    logic                m0_use_imm [NUM_LANES];
    logic [XLEN-1:0]     m0_pc [NUM_LANES];
    logic                m0_pred [NUM_LANES];
    logic [PRF_ID_W-1:0] m0_pdst [NUM_LANES];
    logic [ROB_ID_W-1:0] m0_robid [NUM_LANES];
    logic                m1_valid [NUM_LANES];
    exp_t                m1_res [NUM_LANES];
    logic [PRF_ID_W-1:0] m1_pdst [NUM_LANES];
    logic [ROB_ID_W-1:0] m1_robid [NUM_LANES];

    int                  seed = 32'h2f913d03;
    int                  acc_idx;
    int                  cycle_cnt;
    int                  ready_at [PRF_ENTRIES];
    logic [ROB_ID_W-1:0] next_robid;

    exe_cluster #(
        .NUM_LANES (NUM_LANES)
    ) exe_cluster_inst (
        .clk,
        .rst,
        .stall,
        .flush,
        .iss_valid,
        .iss_op,
        .iss_src1,
        .iss_src2,
        .iss_use_imm,
        .iss_imm,
        .iss_pc,
        .iss_pred_taken,
        .iss_pdst,
        .iss_robid,
        .wb_en,
        .wb_pdst,
        .wb_data,
        .cmp_valid,
        .cmp_robid,
        .cmp_mispred,
        .redirect_valid,
        .redirect_pc
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic mismatch_error(string name, logic [XLEN-1:0] exp_v, logic [XLEN-1:0] act_v);
        $display("[FAIL] time %0t: %s expected 0x%08h, actual 0x%08h", $time, name, exp_v, act_v);
        abort_run();
    endtask

    task automatic protocol_error(string what);
        $display("ERROR at time %0t: %s", $time, what);
        abort_run();
    endtask

    function automatic int unsigned urand(int unsigned n);
        urand = $unsigned($random(seed)) % n;
    endfunction

    // Expected result of one op by the ISA rules
    function automatic exp_t ref_exec(t_exe_op op, logic [XLEN-1:0] a, logic [XLEN-1:0] s2,
                                      logic [XLEN-1:0] imm, logic use_imm, logic [XLEN-1:0] pc,
                                      logic pred, logic [PRF_ID_W-1:0] pdst);
        exp_t            r;
        logic [XLEN-1:0] b;
        logic            is_alu;
        logic            is_br;
        logic            taken;
        b      = use_imm ? imm : s2;
        r      = '0;
        is_alu = 1'b1;
        is_br  = 1'b1;
        taken  = 1'b0;
        case (op)
            OP_ADD:  r.result = a + b;
            OP_SUB:  r.result = a - b;
            OP_AND:  r.result = a & b;
            OP_OR:   r.result = a | b;
            OP_XOR:  r.result = a ^ b;
            OP_SLL:  r.result = a << b[4:0];
            OP_SRL:  r.result = a >> b[4:0];
            OP_SRA:  r.result = $signed(a) >>> b[4:0];
            OP_SLT:  r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: r.result = (a < b) ? 32'd1 : 32'd0;
            OP_LUI:  r.result = b;
            default: is_alu = 1'b0;
        endcase
        case (op)
            OP_BEQ:  taken = (a == s2);
            OP_BNE:  taken = (a != s2);
            OP_BLT:  taken = ($signed(a) < $signed(s2));
            OP_BGE:  taken = ($signed(a) >= $signed(s2));
            OP_BLTU: taken = (a < s2);
            OP_BGEU: taken = (a >= s2);
            OP_JAL:  taken = 1'b1;
            default: is_br = 1'b0;
        endcase
        r.target  = taken ? pc + imm : pc + 32'd4;
        r.mispred = is_br && (taken != pred);
        if (op == OP_JAL) begin
            r.result = pc + 32'd4;
        end
        r.wr = (is_alu || op == OP_JAL) && (pdst != '0);
        return r;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PRF_ENTRIES; r++) begin
                rf_model[r] = '0;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                m0_valid[l] = 1'b0;
                m1_valid[l] = 1'b0;
            end
        end else begin
            if (!stall) begin
                // Writes land before the reads to model the bypass
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (m1_valid[l] && m1_res[l].wr) begin
                        rf_model[m1_pdst[l]] = m1_res[l].result;
                    end
                end
                for (int l = 0; l < NUM_LANES; l++) begin
                    m1_valid[l] = m0_valid[l];
                    m1_res[l]   = ref_exec(m0_op[l], m0_a[l], m0_s2[l], m0_imm[l],
                                           m0_use_imm[l], m0_pc[l], m0_pred[l], m0_pdst[l]);
                    m1_pdst[l]  = m0_pdst[l];
                    m1_robid[l] = m0_robid[l];
                    m0_valid[l]   = iss_valid[l];
                    m0_op[l]      = iss_op[l];
                    m0_a[l]       = rf_model[iss_src1[l]];
                    m0_s2[l]      = rf_model[iss_src2[l]];
                    m0_imm[l]     = iss_imm[l];
                    m0_use_imm[l] = iss_use_imm[l];
                    m0_pc[l]      = iss_pc[l];
                    m0_pred[l]    = iss_pred_taken[l];
                    m0_pdst[l]    = iss_pdst[l];
                    m0_robid[l]   = iss_robid[l];
                end
            end
            if (flush) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    m0_valid[l] = 1'b0;
                    m1_valid[l] = 1'b0;
                end
            end
        end
    end

    task automatic check_outputs();
        logic            exp_live;
        logic            exp_redir;
        logic [XLEN-1:0] exp_pc;
        exp_redir = 1'b0;
        exp_pc    = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_live = m1_valid[l] && !stall;
            assert (cmp_valid[l] == exp_live)
                else protocol_error($sformatf("lane %0d completion %s", l,
                                              exp_live ? "is missing" : "was not expected"));
            assert (wb_en[l] == (exp_live && m1_res[l].wr))
                else mismatch_error($sformatf("wb_en[%0d]", l),
                                    32'(exp_live && m1_res[l].wr), 32'(wb_en[l]));
            if (exp_live) begin
                assert (cmp_robid[l] == m1_robid[l])
                    else mismatch_error($sformatf("cmp_robid[%0d]", l),
                                        32'(m1_robid[l]), 32'(cmp_robid[l]));
                assert (cmp_mispred[l] == m1_res[l].mispred)
                    else mismatch_error($sformatf("cmp_mispred[%0d]", l),
                                        32'(m1_res[l].mispred), 32'(cmp_mispred[l]));
                if (m1_res[l].wr) begin
                    assert (wb_pdst[l] == m1_pdst[l])
                        else mismatch_error($sformatf("wb_pdst[%0d]", l),
                                            32'(m1_pdst[l]), 32'(wb_pdst[l]));
                    assert (wb_data[l] == m1_res[l].result)
                        else mismatch_error($sformatf("wb_data[%0d]", l),
                                            m1_res[l].result, wb_data[l]);
                end
                // First mispredict in lane order is the oldest
                if (!exp_redir && m1_res[l].mispred) begin
                    exp_redir = 1'b1;
                    exp_pc    = m1_res[l].target;
                end
            end
        end
        assert (redirect_valid == exp_redir)
            else mismatch_error("redirect_valid", 32'(exp_redir), 32'(redirect_valid));
        if (exp_redir) begin
            assert (redirect_pc == exp_pc)
                else mismatch_error("redirect_pc", exp_pc, redirect_pc);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_outputs();
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            protocol_error("run exceeded its cycle limit without finishing the tests");
        end
    end

    function automatic logic [PRF_ID_W-1:0] pick_src();
        logic [PRF_ID_W-1:0] r;
        r = PRF_ID_W'(urand(PRF_ENTRIES));
        // Fall back to x0 when the producer is too recent
        if (acc_idx < ready_at[r]) begin
            r = '0;
        end
        return r;
    endfunction

    task automatic fill_slot(int l);
        iss_valid[l]      = 1'b1;
        iss_op[l]         = OP_ADD;
        iss_src1[l]       = pick_src();
        iss_src2[l]       = pick_src();
        iss_use_imm[l]    = 1'b0;
        iss_imm[l]        = $random(seed);
        iss_pc[l]         = {iss_imm[l][15:0], 16'h0} ^ 32'($unsigned($random(seed)) & 32'hfffc);
        iss_pred_taken[l] = 1'(urand(2));
        iss_pdst[l]       = PRF_ID_W'(urand(PRF_ENTRIES));
        iss_robid[l]      = next_robid;
        next_robid        = next_robid + 1'b1;
    endtask

    task automatic random_alu(int l);
        fill_slot(l);
        iss_op[l]      = t_exe_op'(5'(urand(11)));
        iss_use_imm[l] = 1'(urand(2));
        if (iss_op[l] == OP_LUI) begin
            iss_use_imm[l]    = 1'b1;
            iss_imm[l][11:0]  = '0;
        end
    endtask

    task automatic random_branch(int l);
        fill_slot(l);
        iss_op[l]      = t_exe_op'(5'(11 + urand(7)));
        iss_imm[l][0]  = 1'b0;
        // Branch compares src2 whatever use_imm says
        iss_use_imm[l] = 1'(urand(2));
        if (urand(2) == 0) begin
            iss_src2[l] = iss_src1[l];
        end
    endtask

    task automatic note_writers();
        for (int l = 0; l < NUM_LANES; l++) begin
            if (iss_valid[l] && (iss_op[l] <= OP_LUI || iss_op[l] == OP_JAL)) begin
                ready_at[iss_pdst[l]] = acc_idx + 2;
            end
        end
    endtask

    // Slots are held through any stall and taken at the next edge
    task automatic issue_group(int hold, logic do_flush);
        note_writers();
        repeat (hold) begin
            stall = 1'b1;
            flush = 1'b0;
            @(posedge clk);
            #2;
        end
        stall = 1'b0;
        flush = do_flush;
        @(posedge clk);
        #2;
        acc_idx++;
        flush     = 1'b0;
        iss_valid = '0;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            iss_valid = '0;
            issue_group(0, 1'b0);
        end
    endtask

    initial begin
        logic [PRF_ID_W-1:0] cr [2];
        logic [PRF_ID_W-1:0] nr;
        int                  p;
        rst        = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        next_robid = '0;
        acc_idx    = 0;
        cycle_cnt  = 0;
        cr[0]      = '0;
        cr[1]      = '0;
        for (int r = 0; r < PRF_ENTRIES; r++) begin
            ready_at[r] = 0;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            fill_slot(l);
        end
        iss_valid = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        idle_cycles(4);

        // Every register reads zero after reset
        for (int g = 0; g < N_ZERO; g++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                fill_slot(l);
                iss_src1[l] = PRF_ID_W'(2 * g + l);
                iss_src2[l] = PRF_ID_W'(63 - 2 * g - l);
            end
            issue_group(0, 1'b0);
        end

        for (int g = 0; g < N_ALU; g++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                random_alu(l);
                iss_valid[l] = (urand(8) != 0);
            end
            issue_group(0, 1'b0);
        end

        // Chains two groups apart with both lanes writing one register
        for (int g = 0; g < N_CHAIN; g++) begin
            p  = g % 2;
            nr = (p == 0) ? PRF_ID_W'(1 + urand(31)) : PRF_ID_W'(32 + urand(32));
            for (int l = 0; l < NUM_LANES; l++) begin
                random_alu(l);
                iss_src1[l] = cr[p];
                iss_pdst[l] = nr;
            end
            cr[p] = nr;
            issue_group(0, 1'b0);
        end

        for (int g = 0; g < N_BR; g++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                random_branch(l);
                if (g % 4 == 0) begin
                    iss_op[l]         = OP_JAL;
                    iss_pred_taken[l] = 1'b0;
                end
            end
            issue_group(0, 1'b0);
        end

        for (int g = 0; g < N_STALL; g++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                random_alu(l);
            end
            issue_group((urand(3) == 0) ? int'(2 + urand(4)) : 0, 1'b0);
        end

        // Flush kills the group in EX0 and the group offered with it
        for (int g = 0; g < N_FLUSH; g++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                random_alu(l);
            end
            issue_group(0, 1'b0);
            for (int l = 0; l < NUM_LANES; l++) begin
                random_branch(l);
            end
            issue_group(0, 1'b1);
            for (int l = 0; l < NUM_LANES; l++) begin
                random_alu(l);
            end
            issue_group(0, 1'b0);
        end

        idle_cycles(N_IDLE - 4);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exe_cluster.f ====
logic/exe_pkg.sv
logic/exe_alu.sv
logic/exe_branch.sv
logic/exe_lane.sv
logic/exe_regread.sv
logic/exe_complete.sv
logic/exe_cluster.sv
dv/tb_exe_cluster.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_exe_cluster -f exe_cluster.f -o sim_exe_cluster &&
./obj_dir/sim_exe_cluster ||
{ echo "simulation did not complete cleanly"; exit 1; }
